/* l1_split_cache.f */
logic/cache_pkg.sv
logic/cache_wb_slave.sv
logic/tag_store.sv
logic/lru_update.sv
logic/l1_split_cache_top.sv
dv/tb_l1_split_cache.sv

/* Makefile */
TOP := tb_l1_split_cache

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f l1_split_cache.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* dv/tb_l1_split_cache.sv */
// testbench for the split L1 tag model, runs a table of wishbone commands and checks each result
`timescale 1ns/1ps

module tb_l1_split_cache
    import cache_pkg::*;
;

    typedef struct {
        op_t     op;
        index_t  index;
        tag_t    tag;
        result_t exp;  // expected result register after the command
        int      lat;  // expected command ack latency
    } entry_t;

    logic        clk;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic        wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;

    entry_t tbl[$];
    bit     loaded = 1'b0;

    l1_split_cache_top #(.SET_BITS(4)) dut0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void add_entry(op_t op, int idx, int tag, bit hit, int way, bit ev,
                                      int etag);
        entry_t e;
        e.op            = op;
        e.index         = index_t'(idx);
        e.tag           = tag_t'(tag);
        e.exp.hit       = hit;
        e.exp.way       = way_t'(way);
        e.exp.evicted   = ev;
        e.exp.evict_tag = tag_t'(etag);
        e.lat           = 2;
        tbl.push_back(e);
    endfunction

    // expected values follow the true-LRU rules, all in set 3
    function automatic void load_table();
        // cold fills of the data side, ways 0 to 7 in order
        add_entry(OP_DREAD,  3, 'h101, 0, 0, 0, 0);
        add_entry(OP_DREAD,  3, 'h102, 0, 1, 0, 0);
        add_entry(OP_DREAD,  3, 'h103, 0, 2, 0, 0);
        add_entry(OP_DREAD,  3, 'h104, 0, 3, 0, 0);
        add_entry(OP_DREAD,  3, 'h105, 0, 4, 0, 0);
        add_entry(OP_DREAD,  3, 'h106, 0, 5, 0, 0);
        add_entry(OP_DREAD,  3, 'h107, 0, 6, 0, 0);
        add_entry(OP_DREAD,  3, 'h108, 0, 7, 0, 0);
        add_entry(OP_DREAD,  3, 'h101, 1, 0, 0, 0);      // way 0 becomes most recent
        add_entry(OP_DREAD,  3, 'h109, 0, 1, 1, 'h102);  // way 1 held lru 7
        add_entry(OP_DWRITE, 3, 'h105, 1, 4, 0, 0);
        add_entry(OP_DREAD,  3, 'h105, 1, 4, 0, 0);
        // instruction side is separate, 0x101 is not resident there
        add_entry(OP_IFETCH, 3, 'h101, 0, 0, 0, 0);
        add_entry(OP_IFETCH, 3, 'h202, 0, 1, 0, 0);
        add_entry(OP_IFETCH, 3, 'h203, 0, 2, 0, 0);
        add_entry(OP_IFETCH, 3, 'h204, 0, 3, 0, 0);
        add_entry(OP_IFETCH, 3, 'h205, 0, 0, 1, 'h101);
        add_entry(OP_DREAD,  3, 'h205, 0, 2, 1, 'h103);  // data side misses the same tag
        add_entry(OP_IFETCH, 3, 'h202, 1, 1, 0, 0);
        // invalidate frees way 5, refill takes it without an eviction
        add_entry(OP_INVAL,  3, 'h106, 1, 5, 0, 0);
        add_entry(OP_DREAD,  3, 'h106, 0, 5, 0, 0);
        add_entry(OP_INVAL,  3, 'h3ff, 0, 3, 0, 0);      // miss reports the victim way only
        add_entry(OP_DREAD,  3, 'h104, 1, 3, 0, 0);
        // clear keeps the result register
        add_entry(OP_CLEAR,  0, 'h000, 1, 3, 0, 0);
        add_entry(OP_DREAD,  3, 'h108, 0, 0, 0, 0);
        add_entry(OP_IFETCH, 3, 'h205, 0, 0, 0, 0);
    endfunction

    // one classic cycle, lat counts rising edges from stb to ack
    task automatic wb_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int lat);
        bit ack_seen;
        ack_seen = 1'b0;
        lat      = 0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdata;
        while (!ack_seen) begin
            @(negedge clk);  // outputs are settled here
            if (wb_ack_o) begin
                ack_seen = 1'b1;
                rdata    = wb_dat_o;
            end else begin
                lat++;
            end
        end
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic issue_command(input entry_t e, output int lat);
        cmd_t        c;
        logic [31:0] unused_rd;
        c.op    = e.op;
        c.index = e.index;
        c.tag   = e.tag;
        wb_cycle(1'b1, 1'b0, {8'h00, c}, unused_rd, lat);
    endtask

    task automatic read_result(output logic [31:0] word, output int lat);
        wb_cycle(1'b0, 1'b1, 32'h0, word, lat);
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    // whole read word, the result sits zero-extended in the low bits
    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "read word mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "ack latency mismatch");
        end
    endtask

    initial begin
        logic [31:0] rd;
        int          lat;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = 1'b0;
        wb_dat_i = 32'h0;
        load_table();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        foreach (tbl[i]) begin
            issue_command(tbl[i], lat);
            check_latency($sformatf("command wb_ack_o latency, entry %0d", i), lat, tbl[i].lat);
            read_result(rd, lat);
            check_latency($sformatf("read wb_ack_o latency, entry %0d", i), lat, 1);
            check_result($sformatf("wb_dat_o result, entry %0d", i),
                         result_t'(rd[$bits(result_t)-1:0]), tbl[i].exp);
            check_word($sformatf("wb_dat_o word, entry %0d", i), rd, 32'(tbl[i].exp));
        end
        $display("RESULT: PASS");
        $finish;
    end

    // each entry needs well under 10 cycles
    initial begin
        wait (loaded);
        repeat (tbl.size() * 10) @(posedge clk);
        $display("watchdog expired because the wishbone ack never came");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

/* logic/l1_split_cache_top.sv */
// split L1 tag model top with one wishbone front end, an 8-way data side and a 4-way instruction side
`timescale 1ns/1ps

module l1_split_cache_top
    import cache_pkg::*;
#(
    parameter int SET_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic        wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    localparam int D_WAYS = 8;
    localparam int I_WAYS = 4;

    cmd_t               cmd;
    logic               req_d;
    logic               req_i;
    logic               clear;
    line_t [D_WAYS-1:0] d_set_rd;
    line_t [D_WAYS-1:0] d_set_wr;
    logic               d_wr_en;
    result_t            d_res;
    line_t [I_WAYS-1:0] i_set_rd;
    line_t [I_WAYS-1:0] i_set_wr;
    logic               i_wr_en;
    result_t            i_res;

    cache_wb_slave #(.SET_BITS(SET_BITS)) u_slave (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .res_d_i  (d_res),
        .res_i_i  (i_res),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .cmd_o    (cmd),
        .req_d_o  (req_d),
        .req_i_o  (req_i),
        .clear_o  (clear)
    );

    // data side
    tag_store #(.SET_BITS(SET_BITS), .WAYS(D_WAYS)) u_dtags (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .index_i  (cmd.index[SET_BITS-1:0]),
        .set_wr_i (d_set_wr),
        .wr_en_i  (d_wr_en),
        .clear_i  (clear),
        .set_rd_o (d_set_rd)
    );

    lru_update #(.WAYS(D_WAYS)) u_dlru (
        .cmd_i   (cmd),
        .req_i   (req_d),
        .set_i   (d_set_rd),
        .set_o   (d_set_wr),
        .wr_en_o (d_wr_en),
        .res_o   (d_res)
    );

    // instruction side
    tag_store #(.SET_BITS(SET_BITS), .WAYS(I_WAYS)) u_itags (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .index_i  (cmd.index[SET_BITS-1:0]),
        .set_wr_i (i_set_wr),
        .wr_en_i  (i_wr_en),
        .clear_i  (clear),
        .set_rd_o (i_set_rd)
    );

    lru_update #(.WAYS(I_WAYS)) u_ilru (
        .cmd_i   (cmd),
        .req_i   (req_i),
        .set_i   (i_set_rd),
        .set_o   (i_set_wr),
        .wr_en_o (i_wr_en),
        .res_o   (i_res)
    );

endmodule

/* logic/lru_update.sv */
// hit check, victim choice, true-LRU aging and fill or invalidate for one set of one cache
`timescale 1ns/1ps

module lru_update
    import cache_pkg::*;
#(
    parameter int WAYS = 8
) (
    input  cmd_t              cmd_i,
    input  logic              req_i,
    input  line_t [WAYS-1:0]  set_i,
    output line_t [WAYS-1:0]  set_o,
    output logic              wr_en_o,
    output result_t           res_o
);

    localparam int   SEL_W  = $clog2(WAYS);
    localparam lru_t OLDEST = lru_t'(WAYS - 1);

    logic             hit;
    logic [SEL_W-1:0] hit_way;
    logic             any_inv;
    logic [SEL_W-1:0] inv_way;
    logic [SEL_W-1:0] old_way;
    logic [SEL_W-1:0] victim;
    logic [SEL_W-1:0] sel_way;
    lru_t             sel_lru;
    logic             inval;

    assign inval = (cmd_i.op == OP_INVAL);

    // at most one valid way can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (set_i[w].valid && set_i[w].tag == cmd_i.tag) begin
                hit     = 1'b1;
                hit_way = SEL_W'(w);
            end
        end
    end

    always_comb begin
        any_inv = 1'b0;
        inv_way = '0;
        old_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin  // walk down so the lowest invalid way wins
            if (!set_i[w].valid) begin
                any_inv = 1'b1;
                inv_way = SEL_W'(w);
            end
            if (set_i[w].lru == OLDEST) begin
                old_way = SEL_W'(w);
            end
        end
    end

    assign victim  = any_inv ? inv_way : old_way;
    assign sel_way = hit ? hit_way : victim;
    assign sel_lru = set_i[sel_way].lru;

    always_comb begin
        set_o = set_i;
        if (inval) begin
            if (hit) begin
                set_o[sel_way].valid = 1'b0;  // lru order kept as is
            end
        end else begin
            // everything more recent than the selected way moves back one place
            for (int w = 0; w < WAYS; w++) begin
                if (set_i[w].lru < sel_lru) begin
                    set_o[w].lru = set_i[w].lru + 1'b1;
                end
            end
            set_o[sel_way].valid = 1'b1;
            set_o[sel_way].tag   = cmd_i.tag;
            set_o[sel_way].lru   = '0;
        end
    end

    assign wr_en_o = req_i && !(inval && !hit);  // an invalidate miss leaves the set alone

    always_comb begin
        res_o           = '0;
        res_o.hit       = hit;
        res_o.way       = way_t'(sel_way);
        res_o.evicted   = !hit && !inval && set_i[victim].valid;
        res_o.evict_tag = res_o.evicted ? set_i[victim].tag : '0;
    end

endmodule

/* logic/tag_store.sv */
// per-set tag array for one cache with registered set read, write-back and bulk clear
`timescale 1ns/1ps

module tag_store
    import cache_pkg::*;
#(
    parameter int SET_BITS = 4,
    parameter int WAYS     = 8
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [SET_BITS-1:0]  index_i,
    input  line_t [WAYS-1:0]     set_wr_i,
    input  logic                 wr_en_i,
    input  logic                 clear_i,
    output line_t [WAYS-1:0]     set_rd_o
);

    localparam int NSETS = 1 << SET_BITS;

    typedef line_t [WAYS-1:0] set_t;

    // empty set, each way ranked by its own number
    function automatic set_t init_set();
        set_t s;
        for (int w = 0; w < WAYS; w++) begin
            s[w].valid = 1'b0;
            s[w].tag   = '0;
            s[w].lru   = lru_t'(w);
        end
        return s;
    endfunction

    localparam set_t INIT_SET = init_set();

    set_t sets [NSETS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NSETS; s++) begin
                sets[s] <= INIT_SET;
            end
            set_rd_o <= INIT_SET;
        end else begin
            set_rd_o <= sets[index_i];  // ready the cycle after the index
            if (clear_i) begin
                for (int s = 0; s < NSETS; s++) begin
                    sets[s] <= INIT_SET;
                end
            end else if (wr_en_i) begin
                sets[index_i] <= set_wr_i;
            end
        end
    end

endmodule

/* logic/cache_wb_slave.sv */
// wishbone classic front end that decodes cache commands, sequences one lookup and keeps the result
`timescale 1ns/1ps

module cache_wb_slave
    import cache_pkg::*;
#(
    parameter int SET_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic        wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  result_t     res_d_i,
    input  result_t     res_i_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output cmd_t        cmd_o,
    output logic        req_d_o,
    output logic        req_i_o,
    output logic        clear_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,  // set is valid, engine result is taken
        UPDATE,  // clear or unknown op
        ACK
    } state_t;

    localparam index_t IDX_MASK = index_t'((1 << SET_BITS) - 1);

    state_t  state_q;
    state_t  state_d;
    cmd_t    cmd_raw;
    cmd_t    cmd_in;
    cmd_t    cmd_q;
    result_t result_q;
    logic    accept;
    logic    cmd_wr;
    logic    ifetch_q;

    assign accept = wb_cyc_i && wb_stb_i;
    assign cmd_wr = accept && wb_we_i && !wb_adr_i;  // address 0 takes commands

    assign cmd_raw = cmd_t'(wb_dat_i[$bits(cmd_t)-1:0]);

    always_comb begin
        cmd_in       = cmd_raw;
        cmd_in.index = cmd_raw.index & IDX_MASK;  // drop index bits above the set count
    end

    // idle passes the word through so the tag store address registers in cycle 0
    assign cmd_o    = (state_q == IDLE) ? cmd_in : cmd_q;
    assign ifetch_q = (cmd_q.op == OP_IFETCH);  // instruction side selected

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_wr) begin
                    case (cmd_in.op)
                        OP_DREAD, OP_DWRITE, OP_IFETCH, OP_INVAL: state_d = LOOKUP;
                        default:                                  state_d = UPDATE;
                    endcase
                end else if (accept) begin
                    state_d = ACK;  // result read, one cycle
                end
            end
            LOOKUP:  state_d = ACK;
            UPDATE:  state_d = ACK;
            ACK:     state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            result_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) begin
                result_q <= ifetch_q ? res_i_i : res_d_i;  // only the strobed side
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cmd_wr) begin
            cmd_q <= cmd_in;
        end
    end

    assign req_d_o = (state_q == LOOKUP) && !ifetch_q;
    assign req_i_o = (state_q == LOOKUP) && ifetch_q;
    assign clear_o = (state_q == UPDATE) && (cmd_q.op == OP_CLEAR);  // unknown ops fall through

    assign wb_ack_o = (state_q == ACK);
    assign wb_dat_o = {{(32 - $bits(result_t)){1'b0}}, result_q};

endmodule

/* logic/cache_pkg.sv */
// shared types for the split L1 tag model: widths, command ops, line, command and result words
package cache_pkg;

    localparam int TAG_W   = 12;  // tag bits kept per line
    localparam int LRU_W   = 3;   // enough for 8 ways
    localparam int WAY_W   = 3;   // way number as reported in a result
    localparam int INDEX_W = 8;   // index field in the command word

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LRU_W-1:0]   lru_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [INDEX_W-1:0] index_t;

    // command opcodes, low nibble of the write word
    typedef enum logic [3:0] {
        OP_DREAD  = 4'd0,
        OP_DWRITE = 4'd1,
        OP_IFETCH = 4'd2,
        OP_INVAL  = 4'd3,
        OP_CLEAR  = 4'd8
    } op_t;

    // one way of one set, 16 bits
    typedef struct packed {
        logic valid;
        tag_t tag;
        lru_t lru;  // 0 is most recent
    } line_t;

    // write word layout: tag in 23:12, index in 11:4, op in 3:0
    typedef struct packed {
        tag_t   tag;
        index_t index;
        op_t    op;
    } cmd_t;

    // outcome of the last lookup, 17 bits
    typedef struct packed {
        logic hit;
        way_t way;        // hit way or victim way
        logic evicted;    // victim held a valid line
        tag_t evict_tag;  // old tag of the victim, 0 when nothing left
    } result_t;

endpackage
